// ==== src/ibuf_pkg.sv ====
package ibuf_pkg;

    ////////////////////
    // line geometry
    ////////////////////

    // one line is one x86 fetch packet
    localparam int line_width = 128;
    localparam int line_bytes = 16;

    ////////////////////
    // window geometry
    ////////////////////

    // four lines form the circular code window
    localparam int num_lines      = 4;
    localparam int line_idx_width = 2;
    localparam int window_bytes   = 64;

endpackage

// ==== src/fetch_pkg.sv ====
package fetch_pkg;

    ////////////////////
    // pointer widths
    ////////////////////

    // byte pointer into the 64-byte window
    localparam int bip_width = 6;

    // decode length, wider than the pointer
    localparam int length_width = 8;

    ////////////////////
    // control flow
    ////////////////////

    // source of a redirect, ordered by rising priority
    typedef enum logic [1:0] {
        cf_none    = 2'b00,
        cf_branch  = 2'b01,
        cf_resteer = 2'b10,
        cf_init    = 2'b11
    } cf_src_t;

endpackage

// ==== src/ibuf_lines.sv ====
`timescale 1ns/10ps

module ibuf_lines (
    input  logic clk,
    input  logic rst,

    // fill from the memory side
    input  logic [ibuf_pkg::line_width-1:0] fill_data,
    input  logic [ibuf_pkg::line_idx_width-1:0] fill_index,
    input  logic fill_en,

    // release and flush control
    input  logic flush,
    input  logic bip_advance,
    input  logic [fetch_pkg::bip_width-1:0] old_bip,
    input  logic [fetch_pkg::bip_width-1:0] new_bip,

    output logic [ibuf_pkg::num_lines-1:0][ibuf_pkg::line_width-1:0] line_data,
    output logic [ibuf_pkg::num_lines-1:0] line_valid
);

    logic [ibuf_pkg::line_idx_width-1:0] old_line;
    logic [ibuf_pkg::line_idx_width-1:0] new_line;
    logic line_cross;

    // line index is the top bits of the pointer
    assign old_line = old_bip[fetch_pkg::bip_width-1 -: ibuf_pkg::line_idx_width];
    assign new_line = new_bip[fetch_pkg::bip_width-1 -: ibuf_pkg::line_idx_width];

    // pointer left the old line behind
    assign line_cross = bip_advance && (old_line != new_line);

    ////////////////////
    // valid bits
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            line_valid <= '0;
        end else begin
            if (flush) begin
                line_valid <= '0;
            end else if (line_cross) begin
                line_valid[old_line] <= 1'b0;
            end
            // fill wins over any clear in the same cycle
            if (fill_en) begin
                line_valid[fill_index] <= 1'b1;
            end
        end
    end

    ////////////////////
    // line storage
    ////////////////////

    always_ff @(posedge clk) begin
        if (fill_en) begin
            line_data[fill_index] <= fill_data;
        end
    end

endmodule

// ==== src/fetch_pointer.sv ====
`timescale 1ns/10ps

module fetch_pointer (
    input  logic clk,
    input  logic rst,
    input  logic [fetch_pkg::length_width-1:0] length,
    input  logic stall,
    input  logic is_init,
    input  logic [fetch_pkg::bip_width-1:0] init_bip,
    input  logic is_resteer,
    input  logic [fetch_pkg::bip_width-1:0] wb_bip,
    input  logic is_br_taken,
    input  logic [fetch_pkg::bip_width-1:0] bp_bip,
    input  logic idtr_invalidate_fetch,
    input  logic packet_valid,
    output logic is_cf,
    output logic [fetch_pkg::bip_width-1:0] old_bip,
    output logic [fetch_pkg::bip_width-1:0] new_bip,
    output logic bip_advance
);

    fetch_pkg::cf_src_t cf_src;
    logic [fetch_pkg::bip_width-1:0] cf_target;
    logic [fetch_pkg::bip_width-1:0] bip_next;
    logic [fetch_pkg::length_width-1:0] bip_sum;
    logic consumed;
    logic ld_seq;
    logic ld_override;
    logic ld_bip;

    ////////////////////
    // control flow select
    ////////////////////

    // init over resteer over branch
    always_comb begin
        if (is_init) begin
            cf_src = fetch_pkg::cf_init;
        end else if (is_resteer) begin
            cf_src = fetch_pkg::cf_resteer;
        end else if (is_br_taken) begin
            cf_src = fetch_pkg::cf_branch;
        end else begin
            cf_src = fetch_pkg::cf_none;
        end
    end

    always_comb begin
        case (cf_src)
            fetch_pkg::cf_init:    cf_target = init_bip;
            fetch_pkg::cf_resteer: cf_target = wb_bip;
            fetch_pkg::cf_branch:  cf_target = bp_bip;
            default:               cf_target = new_bip;
        endcase
    end

    assign is_cf = (cf_src != fetch_pkg::cf_none);

    ////////////////////
    // pointer adder
    ////////////////////

    // sum wraps at the window size
    assign bip_sum = {{(fetch_pkg::length_width - fetch_pkg::bip_width){1'b0}}, old_bip} + length;
    assign new_bip = bip_sum[fetch_pkg::bip_width-1:0];

    ////////////////////
    // bip register
    ////////////////////

    assign ld_seq      = !stall && consumed;
    assign ld_override = is_resteer && !idtr_invalidate_fetch;
    assign ld_bip      = is_cf || ld_seq || ld_override;
    assign bip_advance = ld_seq && !is_cf;

    always_comb begin
        if (is_cf) begin
            bip_next = cf_target;
        end else if (ld_override) begin
            bip_next = wb_bip;
        end else begin
            bip_next = new_bip;
        end
    end

    // consumed flag tracks the packet decode just took
    always_ff @(posedge clk) begin
        if (rst) begin
            consumed <= 1'b0;
        end else if (!stall) begin
            consumed <= packet_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            old_bip <= '0;
        end else if (ld_bip) begin
            old_bip <= bip_next;
        end
    end

endmodule

// ==== src/line_rotator.sv ====
`timescale 1ns/10ps

module line_rotator (
    input  logic [ibuf_pkg::num_lines-1:0][ibuf_pkg::line_width-1:0] lines,
    input  logic [fetch_pkg::bip_width-1:0] rot_bip,
    output logic [ibuf_pkg::line_width-1:0] packet
);

    localparam int byte_bits   = ibuf_pkg::line_width / ibuf_pkg::line_bytes;
    localparam int window_bits = ibuf_pkg::window_bytes * byte_bits;

    // one window per rotate layer, layer 0 is the input
    logic [fetch_pkg::bip_width:0][window_bits-1:0] layer;

    ////////////////////
    // byte reversal
    ////////////////////

    // byte 0 of each line lands in the top byte, line 0 on top
    for (genvar l = 0; l < ibuf_pkg::num_lines; l++) begin : g_line
        for (genvar b = 0; b < ibuf_pkg::line_bytes; b++) begin : g_byte
            assign layer[0][window_bits - 1 - (l*ibuf_pkg::line_bytes + b)*byte_bits
                            -: byte_bits] = lines[l][b*byte_bits +: byte_bits];
        end
    end

    ////////////////////
    // log rotate
    ////////////////////

    // each layer rotates left by a power of two bytes
    for (genvar s = 0; s < fetch_pkg::bip_width; s++) begin : g_stage
        localparam int sh = (1 << s) * byte_bits;
        assign layer[s+1] = rot_bip[s] ?
            {layer[s][window_bits-sh-1:0], layer[s][window_bits-1 -: sh]} :
            layer[s];
    end

    // top 16 bytes start at the pointer
    assign packet = layer[fetch_pkg::bip_width][window_bits-1 -: ibuf_pkg::line_width];

endmodule

// ==== src/fetch_stage.sv ====
`timescale 1ns/10ps

module fetch_stage (
    input  logic clk,
    input  logic rst,

    // instruction buffer
    input  logic [ibuf_pkg::num_lines-1:0][ibuf_pkg::line_width-1:0] line_data,
    input  logic [ibuf_pkg::num_lines-1:0] line_valid,

    // decode
    input  logic [fetch_pkg::length_width-1:0] length,
    input  logic stall,

    // control flow sources
    input  logic is_init,
    input  logic [fetch_pkg::bip_width-1:0] init_bip,
    input  logic is_resteer,
    input  logic [fetch_pkg::bip_width-1:0] wb_bip,
    input  logic is_br_taken,
    input  logic [fetch_pkg::bip_width-1:0] bp_bip,

    // interrupt path
    input  logic [ibuf_pkg::line_width-1:0] idtr_packet,
    input  logic packet_select,
    input  logic wb_ie_val,
    input  logic idtr_invalidate_fetch,

    output logic [ibuf_pkg::line_width-1:0] packet_out,
    output logic packet_out_valid,
    output logic [fetch_pkg::bip_width-1:0] old_bip,
    output logic [fetch_pkg::bip_width-1:0] new_bip,
    output logic bip_advance
);

    logic is_cf;
    logic [ibuf_pkg::line_width-1:0] rot_packet;
    logic [ibuf_pkg::line_idx_width-1:0] cur_line;
    logic [ibuf_pkg::line_idx_width-1:0] nxt_line;
    logic fetch_valid;

    fetch_pointer u_pointer (
        .clk                   (clk),
        .rst                   (rst),
        .length                (length),
        .stall                 (stall),
        .is_init               (is_init),
        .init_bip              (init_bip),
        .is_resteer            (is_resteer),
        .wb_bip                (wb_bip),
        .is_br_taken           (is_br_taken),
        .bp_bip                (bp_bip),
        .idtr_invalidate_fetch (idtr_invalidate_fetch),
        .packet_valid          (packet_out_valid),
        .is_cf                 (is_cf),
        .old_bip               (old_bip),
        .new_bip               (new_bip),
        .bip_advance           (bip_advance)
    );

    line_rotator u_rotator (
        .lines   (line_data),
        .rot_bip (new_bip),
        .packet  (rot_packet)
    );

    ////////////////////
    // packet valid
    ////////////////////

    // the packet may spill into the next line, which wraps mod 4
    assign cur_line = new_bip[fetch_pkg::bip_width-1 -: ibuf_pkg::line_idx_width];
    assign nxt_line = cur_line + 2'd1;

    assign fetch_valid = line_valid[cur_line] && line_valid[nxt_line]
                         && !is_cf && !wb_ie_val;

    // idtr packet overrides the fetched one
    assign packet_out_valid = fetch_valid || packet_select;
    assign packet_out       = packet_select ? idtr_packet : rot_packet;

endmodule

// ==== src/fetch_top.sv ====
`timescale 1ns/10ps

module fetch_top (
    input  logic clk,
    input  logic rst,

    // line fill
    input  logic [ibuf_pkg::line_width-1:0] fill_data,
    input  logic [ibuf_pkg::line_idx_width-1:0] fill_index,
    input  logic fill_en,

    // decode
    input  logic [fetch_pkg::length_width-1:0] length,
    input  logic stall,

    // writeback
    input  logic [fetch_pkg::bip_width-1:0] wb_bip,
    input  logic is_resteer,

    // branch predictor
    input  logic [fetch_pkg::bip_width-1:0] bp_bip,
    input  logic is_br_taken,

    // init
    input  logic [fetch_pkg::bip_width-1:0] init_bip,
    input  logic is_init,

    // interrupt
    input  logic [ibuf_pkg::line_width-1:0] idtr_packet,
    input  logic packet_select,
    input  logic wb_ie_val,
    input  logic idtr_invalidate_fetch,

    output logic [ibuf_pkg::line_width-1:0] packet_out,
    output logic packet_out_valid,
    output logic [fetch_pkg::bip_width-1:0] old_bip,
    output logic [fetch_pkg::bip_width-1:0] new_bip,
    output logic [ibuf_pkg::num_lines-1:0] line_valid
);

    logic [ibuf_pkg::num_lines-1:0][ibuf_pkg::line_width-1:0] line_data;
    logic bip_advance;
    logic flush;

    // any redirect from init or writeback empties the buffer
    assign flush = is_init || is_resteer;

    ibuf_lines u_ibuf (
        .clk         (clk),
        .rst         (rst),
        .fill_data   (fill_data),
        .fill_index  (fill_index),
        .fill_en     (fill_en),
        .flush       (flush),
        .bip_advance (bip_advance),
        .old_bip     (old_bip),
        .new_bip     (new_bip),
        .line_data   (line_data),
        .line_valid  (line_valid)
    );

    fetch_stage u_fetch (
        .clk                   (clk),
        .rst                   (rst),
        .line_data             (line_data),
        .line_valid            (line_valid),
        .length                (length),
        .stall                 (stall),
        .is_init               (is_init),
        .init_bip              (init_bip),
        .is_resteer            (is_resteer),
        .wb_bip                (wb_bip),
        .is_br_taken           (is_br_taken),
        .bp_bip                (bp_bip),
        .idtr_packet           (idtr_packet),
        .packet_select         (packet_select),
        .wb_ie_val             (wb_ie_val),
        .idtr_invalidate_fetch (idtr_invalidate_fetch),
        .packet_out            (packet_out),
        .packet_out_valid      (packet_out_valid),
        .old_bip               (old_bip),
        .new_bip               (new_bip),
        .bip_advance           (bip_advance)
    );

endmodule

// ==== bench/fetch_tb.sv ====
`timescale 1ns/10ps

module fetch_tb;

    // phase lengths in cycles
    localparam int reset_cycles   = 2;
    localparam int start_cycles   = 8;
    localparam int advance_cycles = 300;
    localparam int release_cycles = 60;
    localparam int stall_cycles   = 150;
    localparam int cf_cycles      = 200;
    localparam int irq_cycles     = 100;
    localparam int total_cycles   = reset_cycles + start_cycles + advance_cycles
                                    + release_cycles + stall_cycles + cf_cycles
                                    + irq_cycles + 4;
    localparam int cycle_limit    = 2 * total_cycles;

    logic clk;
    logic rst;
    logic [ibuf_pkg::line_width-1:0] fill_data;
    logic [ibuf_pkg::line_idx_width-1:0] fill_index;
    logic fill_en;
    logic [fetch_pkg::length_width-1:0] length;
    logic stall;
    logic [fetch_pkg::bip_width-1:0] wb_bip;
    logic is_resteer;
    logic [fetch_pkg::bip_width-1:0] bp_bip;
    logic is_br_taken;
    logic [fetch_pkg::bip_width-1:0] init_bip;
    logic is_init;
    logic [ibuf_pkg::line_width-1:0] idtr_packet;
    logic packet_select;
    logic wb_ie_val;
    logic idtr_invalidate_fetch;
    logic [ibuf_pkg::line_width-1:0] packet_out;
    logic packet_out_valid;
    logic [fetch_pkg::bip_width-1:0] old_bip;
    logic [fetch_pkg::bip_width-1:0] new_bip;
    logic [ibuf_pkg::num_lines-1:0] line_valid;

    // reference model state
    logic [ibuf_pkg::line_width-1:0] m_line [ibuf_pkg::num_lines];
    logic [ibuf_pkg::num_lines-1:0] m_valid;
    logic [fetch_pkg::bip_width-1:0] m_bip;
    logic m_consumed;

    // expected values for the current cycle
    fetch_pkg::cf_src_t exp_src;
    logic exp_cf;
    logic [fetch_pkg::bip_width-1:0] exp_target;
    logic [fetch_pkg::bip_width-1:0] exp_new;
    logic exp_valid;
    logic [ibuf_pkg::line_width-1:0] exp_packet;

    logic [31:0] rng;
    int n_checks;
    int err_packet;
    int err_valid;
    int err_bip;
    int err_lines;
    int cycles;

    fetch_top dut0 (
        .clk                   (clk),
        .rst                   (rst),
        .fill_data             (fill_data),
        .fill_index            (fill_index),
        .fill_en               (fill_en),
        .length                (length),
        .stall                 (stall),
        .wb_bip                (wb_bip),
        .is_resteer            (is_resteer),
        .bp_bip                (bp_bip),
        .is_br_taken           (is_br_taken),
        .init_bip              (init_bip),
        .is_init               (is_init),
        .idtr_packet           (idtr_packet),
        .packet_select         (packet_select),
        .wb_ie_val             (wb_ie_val),
        .idtr_invalidate_fetch (idtr_invalidate_fetch),
        .packet_out            (packet_out),
        .packet_out_valid      (packet_out_valid),
        .old_bip               (old_bip),
        .new_bip               (new_bip),
        .line_valid            (line_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // random helpers
    ////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic [ibuf_pkg::line_width-1:0] rand_line();
        logic [ibuf_pkg::line_width-1:0] d;
        for (int i = 0; i < ibuf_pkg::line_width / 32; i++) begin
            d[i*32 +: 32] = next_rand();
        end
        return d;
    endfunction

    // decode lengths of 1 to 15 bytes
    function automatic logic [fetch_pkg::length_width-1:0] rand_length();
        logic [31:0] r;
        logic [3:0] n;
        r = next_rand();
        n = r[3:0];
        if (n == 4'd0) begin
            n = 4'd1;
        end
        return {4'd0, n};
    endfunction

    ////////////////////
    // reference model
    ////////////////////

    // byte k of the packet is window byte bip + k, top byte first
    function automatic logic [ibuf_pkg::line_width-1:0] expected_packet(
        input logic [fetch_pkg::bip_width-1:0] bip
    );
        logic [ibuf_pkg::line_width-1:0] p;
        logic [fetch_pkg::bip_width-1:0] b;
        for (int k = 0; k < ibuf_pkg::line_bytes; k++) begin
            b = bip + k[fetch_pkg::bip_width-1:0];
            p[ibuf_pkg::line_width-1-8*k -: 8] = m_line[b[5:4]][8*b[3:0] +: 8];
        end
        return p;
    endfunction

    task automatic compute_expected();
        logic [fetch_pkg::length_width-1:0] sum;
        logic [ibuf_pkg::line_idx_width-1:0] cur;
        logic [ibuf_pkg::line_idx_width-1:0] nxt;
        sum = {2'b00, m_bip} + length;
        exp_new = sum[fetch_pkg::bip_width-1:0];
        if (is_init) begin
            exp_src = fetch_pkg::cf_init;
        end else if (is_resteer) begin
            exp_src = fetch_pkg::cf_resteer;
        end else if (is_br_taken) begin
            exp_src = fetch_pkg::cf_branch;
        end else begin
            exp_src = fetch_pkg::cf_none;
        end
        case (exp_src)
            fetch_pkg::cf_init:    exp_target = init_bip;
            fetch_pkg::cf_resteer: exp_target = wb_bip;
            fetch_pkg::cf_branch:  exp_target = bp_bip;
            default:               exp_target = exp_new;
        endcase
        exp_cf = (exp_src != fetch_pkg::cf_none);
        cur = exp_new[5:4];
        nxt = cur + 2'd1;
        exp_valid = (m_valid[cur] && m_valid[nxt] && !exp_cf && !wb_ie_val) || packet_select;
        exp_packet = packet_select ? idtr_packet : expected_packet(exp_new);
    endtask

    // state update at the rising edge
    always @(posedge clk) begin : model_update
        logic advance;
        logic [ibuf_pkg::line_idx_width-1:0] old_line;
        if (rst) begin
            m_bip = '0;
            m_consumed = 1'b0;
            m_valid = '0;
        end else begin
            advance = !stall && m_consumed && !exp_cf;
            old_line = m_bip[5:4];
            if (is_init || is_resteer) begin
                m_valid = '0;
            end else if (advance && (old_line != exp_new[5:4])) begin
                m_valid[old_line] = 1'b0;
            end
            if (fill_en) begin
                m_line[fill_index] = fill_data;
                m_valid[fill_index] = 1'b1;
            end
            if (exp_cf) begin
                m_bip = exp_target;
            end else if (!stall && m_consumed) begin
                m_bip = exp_new;
            end else if (is_resteer && !idtr_invalidate_fetch) begin
                m_bip = wb_bip;
            end
            if (!stall) begin
                m_consumed = exp_valid;
            end
        end
    end

    ////////////////////
    // compare tasks
    ////////////////////

    task automatic check_packet(input logic [ibuf_pkg::line_width-1:0] got,
                                input logic [ibuf_pkg::line_width-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            err_packet++;
            $display("FAIL %0t: packet_out %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_valid(input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            err_valid++;
            $display("FAIL %0t: packet_out_valid %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_bip(input logic [fetch_pkg::bip_width-1:0] got,
                             input logic [fetch_pkg::bip_width-1:0] exp, input string what);
        n_checks++;
        if (got !== exp) begin
            err_bip++;
            $display("FAIL %0t: %s %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_lines(input logic [ibuf_pkg::num_lines-1:0] got,
                               input logic [ibuf_pkg::num_lines-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            err_lines++;
            $display("FAIL %0t: line_valid %b, expected %b", $time, got, exp);
        end
    endtask

    // one time step after the falling edge, well before the rising one
    initial begin : compare
        forever begin
            @(negedge clk);
            #1;
            compute_expected();
            if (!rst) begin
                check_valid(packet_out_valid, exp_valid);
                if (exp_valid) begin
                    check_packet(packet_out, exp_packet);
                end
                check_bip(old_bip, m_bip, "old_bip");
                check_bip(new_bip, exp_new, "new_bip");
                check_lines(line_valid, m_valid);
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("run timed out after %0d cycles", cycles);
        $display("Test failed");
        $finish;
    end

    ////////////////////
    // stimulus
    ////////////////////

    task automatic idle_inputs();
        fill_en = 1'b0;
        stall = 1'b0;
        is_init = 1'b0;
        is_resteer = 1'b0;
        is_br_taken = 1'b0;
        packet_select = 1'b0;
        wb_ie_val = 1'b0;
        idtr_invalidate_fetch = 1'b0;
    endtask

    // memory side refills the lowest empty line
    task automatic refill_missing();
        for (int i = ibuf_pkg::num_lines - 1; i >= 0; i--) begin
            if (!m_valid[i]) begin
                fill_en = 1'b1;
                fill_index = i[ibuf_pkg::line_idx_width-1:0];
                fill_data = rand_line();
            end
        end
    endtask

    initial begin : stimulus
        logic [31:0] r;
        rng = 32'h6072;
        n_checks = 0;
        err_packet = 0;
        err_valid = 0;
        err_bip = 0;
        err_lines = 0;
        rst = 1'b1;
        fill_data = '0;
        fill_index = '0;
        length = '0;
        wb_bip = '0;
        bp_bip = '0;
        init_bip = '0;
        idtr_packet = '0;
        idle_inputs();
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // reset state, then lines 0 and 1 with the pointer parked at 0
        @(negedge clk);
        fill_en = 1'b1;
        fill_index = 2'd0;
        fill_data = rand_line();
        @(negedge clk);
        fill_index = 2'd1;
        fill_data = rand_line();
        repeat (start_cycles - 3) begin
            @(negedge clk);
            idle_inputs();
        end

        // sequential advance with wrap
        for (int i = 0; i < advance_cycles; i++) begin
            @(negedge clk);
            idle_inputs();
            refill_missing();
            length = rand_length();
        end

        // no refills for a while, so lines drain
        for (int i = 0; i < release_cycles; i++) begin
            @(negedge clk);
            idle_inputs();
            length = rand_length();
            if (i >= release_cycles / 2) begin
                refill_missing();
            end
        end

        for (int i = 0; i < stall_cycles; i++) begin
            @(negedge clk);
            idle_inputs();
            refill_missing();
            length = rand_length();
            r = next_rand();
            stall = r[0];
        end

        // all three sources at once, then resteer with branch
        @(negedge clk);
        idle_inputs();
        is_init = 1'b1;
        is_resteer = 1'b1;
        is_br_taken = 1'b1;
        init_bip = 6'd5;
        wb_bip = 6'd20;
        bp_bip = 6'd40;
        @(negedge clk);
        idle_inputs();
        is_resteer = 1'b1;
        is_br_taken = 1'b1;
        wb_bip = 6'd33;
        bp_bip = 6'd9;
        for (int i = 0; i < cf_cycles - 2; i++) begin
            @(negedge clk);
            idle_inputs();
            refill_missing();
            length = rand_length();
            r = next_rand();
            is_init = (r[3:0] == 4'd0);
            is_resteer = (r[7:4] == 4'd0);
            is_br_taken = (r[10:8] == 3'd0);
            stall = (r[12:11] == 2'd0);
            idtr_invalidate_fetch = r[13];
            init_bip = r[19:14];
            wb_bip = r[25:20];
            bp_bip = r[31:26];
        end

        // interrupt path
        for (int i = 0; i < irq_cycles; i++) begin
            @(negedge clk);
            idle_inputs();
            refill_missing();
            length = rand_length();
            r = next_rand();
            wb_ie_val = (r[1:0] == 2'd0);
            packet_select = (r[3:2] == 2'd0);
            idtr_packet = rand_line();
        end

        @(negedge clk);
        idle_inputs();
        repeat (2) @(negedge clk);
        $display("checks %0d, errors %0d (packet %0d, valid %0d, bip %0d, lines %0d)",
                 n_checks, err_packet + err_valid + err_bip + err_lines,
                 err_packet, err_valid, err_bip, err_lines);
        if (err_packet + err_valid + err_bip + err_lines == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
src/ibuf_pkg.sv
src/fetch_pkg.sv
src/ibuf_lines.sv
src/fetch_pointer.sv
src/line_rotator.sv
src/fetch_stage.sv
src/fetch_top.sv
bench/fetch_tb.sv

// ==== Makefile ====
# Verilator build and run for the fetch front end

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
